/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
TOP       ?= tb_ex_stage
FILELIST  ?= tb.f
RTL_TOP   ?= ex_stage

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "=== PASS ==="

lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

/* tb.f */
+incdir+testbench
verilog/ex_pkg.sv
verilog/ex_decode.sv
verilog/int_alu.sv
verilog/div_ctrl.sv
verilog/div_counter.sv
verilog/div_datapath.sv
verilog/ex_stage.sv
testbench/tb_ex_stage.sv

/* testbench/ex_ref.svh */
`ifndef EX_REF_SVH
`define EX_REF_SVH

// Expected integer result of one ALU-class instruction
function automatic logic [31:0] ref_alu(input logic [31:0] word, input logic [31:0] rs,
		input logic [31:0] rt);
	logic [5:0]  op;
	logic [5:0]  fn;
	logic [31:0] simm;
	logic [31:0] zimm;
	logic [31:0] src;
	int          n;
	op   = word[31:26];
	fn   = word[5:0];
	zimm = {16'd0, word[15:0]};
	simm = {{16{word[15]}}, word[15:0]};
	case (op)
		ex_pkg::OP_SPECIAL: begin
			case (fn)
				ex_pkg::FN_ADD, ex_pkg::FN_ADDU: return rs + rt;
				ex_pkg::FN_SUB, ex_pkg::FN_SUBU: return rs - rt;
				ex_pkg::FN_AND:  return rs & rt;
				ex_pkg::FN_OR:   return rs | rt;
				ex_pkg::FN_XOR:  return rs ^ rt;
				ex_pkg::FN_NOR:  return ~(rs | rt);
				ex_pkg::FN_SLT:  return ($signed(rs) < $signed(rt)) ? 32'd1 : 32'd0;
				ex_pkg::FN_SLTU: return (rs < rt) ? 32'd1 : 32'd0;
				ex_pkg::FN_SLL:  return rt << word[10:6];
				ex_pkg::FN_SRL:  return rt >> word[10:6];
				ex_pkg::FN_SRA:  return $signed(rt) >>> word[10:6];
				ex_pkg::FN_SLLV: return rt << rs[4:0];
				ex_pkg::FN_SRLV: return rt >> rs[4:0];
				ex_pkg::FN_SRAV: return $signed(rt) >>> rs[4:0];
				default:         return 32'd0;
			endcase
		end
		ex_pkg::OP_SPECIAL2: begin
			// Count from the top bit down
			src = (fn == ex_pkg::FN_CLO) ? ~rs : rs;
			n = 0;
			while (n < 32 && !src[31 - n]) begin
				n++;
			end
			return 32'(n);
		end
		ex_pkg::OP_ADDI, ex_pkg::OP_ADDIU: return rs + simm;
		ex_pkg::OP_SLTI:  return ($signed(rs) < $signed(simm)) ? 32'd1 : 32'd0;
		ex_pkg::OP_SLTIU: return (rs < simm) ? 32'd1 : 32'd0;
		ex_pkg::OP_ANDI:  return rs & zimm;
		ex_pkg::OP_ORI:   return rs | zimm;
		ex_pkg::OP_XORI:  return rs ^ zimm;
		ex_pkg::OP_LUI:   return {word[15:0], 16'd0};
		default:          return 32'd0;
	endcase
endfunction

// Signed overflow of ADD, ADDI and SUB only
function automatic logic ref_overflow(input logic [31:0] word, input logic [31:0] rs,
		input logic [31:0] rt);
	longint a;
	longint b;
	longint s;
	a = longint'($signed(rs));
	b = longint'($signed(rt));
	if (word[31:26] == ex_pkg::OP_ADDI) begin
		s = a + longint'($signed(word[15:0]));
	end else if (word[31:26] == ex_pkg::OP_SPECIAL && word[5:0] == ex_pkg::FN_ADD) begin
		s = a + b;
	end else if (word[31:26] == ex_pkg::OP_SPECIAL && word[5:0] == ex_pkg::FN_SUB) begin
		s = a - b;
	end else begin
		return 1'b0;
	end
	return (s > 64'sd2147483647) || (s < -64'sd2147483648);
endfunction

function automatic logic ref_branch(input logic [31:0] word, input logic [31:0] rs,
		input logic [31:0] rt);
	case (word[31:26])
		ex_pkg::OP_BEQ:    return rs == rt;
		ex_pkg::OP_BNE:    return rs != rt;
		ex_pkg::OP_BLEZ:   return $signed(rs) <= 0;
		ex_pkg::OP_BGTZ:   return $signed(rs) > 0;
		ex_pkg::OP_REGIMM: return word[16] ? ($signed(rs) >= 0) : ($signed(rs) < 0);
		default:           return 1'b0;
	endcase
endfunction

// Truncating division on magnitudes, remainder takes the dividend sign
function automatic logic [31:0] ref_div(input logic sgn, input logic [31:0] a,
		input logic [31:0] b, input logic want_rem);
	logic [31:0] ua;
	logic [31:0] ub;
	logic [31:0] q;
	logic [31:0] r;
	ua = (sgn && a[31]) ? -a : a;
	ub = (sgn && b[31]) ? -b : b;
	q = ua / ub;
	r = ua % ub;
	if (sgn && (a[31] ^ b[31])) begin
		q = -q;
	end
	if (sgn && a[31]) begin
		r = -r;
	end
	return want_rem ? r : q;
endfunction

`endif

/* testbench/tb_ex_stage.sv */
`timescale 1ns/1ps
module tb_ex_stage;
	`include "ex_ref.svh"

	typedef struct {
		string       name;
		logic [31:0] result;
		logic [4:0]  waddr;
		logic        regwrite;
		logic        overflow;
		logic        taken;
		logic        mispredict;
		bit          chk_result;
	} expect_t;

	logic        clk;
	logic        reset;
	logic        issue;
	logic [31:0] instr;
	logic [31:0] rs_data;
	logic [31:0] rt_data;
	logic        guess_taken;
	logic [31:0] result;
	logic [4:0]  reg_waddr;
	logic        result_valid;
	logic        regwrite;
	logic        overflow;
	logic        branch_taken;
	logic        mispredict;
	logic        busy;

	expect_t     pending[$];
	integer      seed = 32'h10c7d511;
	int          checks = 0;
	int          errors = 0;
	logic [31:0] model_hi = 32'd0;
	logic [31:0] model_lo = 32'd0;

	ex_stage ex_stage_inst (
		.clk          (clk),
		.reset        (reset),
		.issue        (issue),
		.instr        (instr),
		.rs_data      (rs_data),
		.rt_data      (rt_data),
		.guess_taken  (guess_taken),
		.result       (result),
		.reg_waddr    (reg_waddr),
		.result_valid (result_valid),
		.regwrite     (regwrite),
		.overflow     (overflow),
		.branch_taken (branch_taken),
		.mispredict   (mispredict),
		.busy         (busy)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("FAIL %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("=== FAIL ===");
		$finish;
	endtask

	// Compare process, outputs are stable at the falling edge
	always @(negedge clk) begin
		expect_t e;
		if (!reset && result_valid) begin
			if (pending.size() == 0) begin
				errors++;
				$display("result_valid pulsed with no instruction outstanding");
			end else begin
				e = pending.pop_front();
				if (e.chk_result) begin
					check_value({e.name, " result"}, e.result, result);
					check_value({e.name, " waddr"}, 32'(e.waddr), 32'(reg_waddr));
				end
				check_value({e.name, " regwrite"}, 32'(e.regwrite), 32'(regwrite));
				check_value({e.name, " overflow"}, 32'(e.overflow), 32'(overflow));
				check_value({e.name, " taken"}, 32'(e.taken), 32'(branch_taken));
				check_value({e.name, " mispredict"}, 32'(e.mispredict), 32'(mispredict));
			end
		end
	end

	task automatic wait_results();
		int n;
		n = 0;
		while (pending.size() != 0 && n < 10) begin
			@(negedge clk);
			n++;
		end
		if (pending.size() != 0) begin
			abort_run("Timed out waiting for result_valid");
		end
	endtask

	task automatic wait_idle(output int cycles);
		cycles = 0;
		while (busy && cycles < 40) begin
			@(negedge clk);
			cycles++;
		end
		if (busy) begin
			abort_run("Timed out waiting for busy to fall");
		end
	endtask

	// One issue pulse, then wait for its result when one is expected
	task automatic send(input logic [31:0] word, input logic [31:0] rs, input logic [31:0] rt,
			input logic guess, input bit has_result, input expect_t e);
		@(negedge clk);
		issue       = 1'b1;
		instr       = word;
		rs_data     = rs;
		rt_data     = rt;
		guess_taken = guess;
		if (has_result) begin
			pending.push_back(e);
		end
		@(negedge clk);
		issue = 1'b0;
		// Result is due on the edge right after the issue cycle
		check_value("result_valid after issue", 32'(has_result), 32'(result_valid));
		wait_results();
	endtask

	task automatic run_alu(input string name, input logic [31:0] word, input logic [31:0] rs,
			input logic [31:0] rt);
		expect_t e;
		logic    ovf;
		ovf = ref_overflow(word, rs, rt);
		e.name       = name;
		e.result     = ref_alu(word, rs, rt);
		e.waddr      = (word[31:26] == ex_pkg::OP_SPECIAL ||
		                word[31:26] == ex_pkg::OP_SPECIAL2) ? word[15:11] : word[20:16];
		e.regwrite   = !ovf;
		e.overflow   = ovf;
		e.taken      = 1'b0;
		e.mispredict = 1'b0;
		e.chk_result = !ovf;
		send(word, rs, rt, 1'b0, 1'b1, e);
	endtask

	task automatic read_hilo(input string name, input bit from_hi, input logic [31:0] expected);
		ex_pkg::instr_word_u w;
		expect_t             e;
		w = '0;
		w.r_fields.rd    = 5'd9;
		w.r_fields.funct = from_hi ? ex_pkg::FN_MFHI : ex_pkg::FN_MFLO;
		e.name       = name;
		e.result     = expected;
		e.waddr      = 5'd9;
		e.regwrite   = 1'b1;
		e.overflow   = 1'b0;
		e.taken      = 1'b0;
		e.mispredict = 1'b0;
		e.chk_result = 1'b1;
		send(w, 32'd0, 32'd0, 1'b0, 1'b1, e);
	endtask

	task automatic write_hilo(input bit to_hi, input logic [31:0] value);
		ex_pkg::instr_word_u w;
		expect_t             e;
		w = '0;
		w.r_fields.funct = to_hi ? ex_pkg::FN_MTHI : ex_pkg::FN_MTLO;
		e.name       = to_hi ? "mthi" : "mtlo";
		e.result     = 32'd0;
		e.waddr      = 5'd0;
		e.regwrite   = 1'b0;
		e.overflow   = 1'b0;
		e.taken      = 1'b0;
		e.mispredict = 1'b0;
		e.chk_result = 1'b0;
		send(w, value, 32'd0, 1'b0, 1'b1, e);
		if (to_hi) begin
			model_hi = value;
		end else begin
			model_lo = value;
		end
	endtask

	task automatic run_branch(input logic [31:0] word, input logic [31:0] rs,
			input logic [31:0] rt, input logic guess);
		expect_t e;
		e.name       = "branch";
		e.result     = 32'd0;
		e.waddr      = 5'd0;
		e.regwrite   = 1'b0;
		e.overflow   = 1'b0;
		e.taken      = ref_branch(word, rs, rt);
		e.mispredict = e.taken != guess;
		e.chk_result = 1'b0;
		send(word, rs, rt, guess, 1'b1, e);
	endtask

	// Divide, optionally with an issue attempt in the middle of it
	task automatic run_div(input logic sgn, input logic [31:0] a, input logic [31:0] b,
			input bit poke);
		ex_pkg::instr_word_u w;
		ex_pkg::instr_word_u mt;
		expect_t             e;
		int                  cycles;
		w = '0;
		w.r_fields.funct = sgn ? ex_pkg::FN_DIV : ex_pkg::FN_DIVU;
		send(w, a, b, 1'b0, 1'b0, e);
		check_value("busy after div", 32'(b != 32'd0), 32'(busy));
		if (poke) begin
			repeat (3) @(negedge clk);
			mt = '0;
			mt.r_fields.funct = ex_pkg::FN_MTHI;
			send(mt, 32'hdeadbeef, 32'd0, 1'b0, 1'b0, e);
		end
		wait_idle(cycles);
		if (!poke && b != 32'd0) begin
			check_value("div busy cycles", 32'(ex_pkg::DIV_STEPS + 2), 32'(cycles));
		end
		if (b != 32'd0) begin
			model_lo = ref_div(sgn, a, b, 1'b0);
			model_hi = ref_div(sgn, a, b, 1'b1);
		end
		read_hilo("div lo", 1'b0, model_lo);
		read_hilo("div hi", 1'b1, model_hi);
	endtask

	task automatic report(input string name, input int errs_before);
		$display("test %s: %0d errors", name, errors - errs_before);
	endtask

	initial begin
		logic [5:0]  r_fn[16];
		logic [5:0]  i_op[8];
		logic [31:0] br_word[6];
		ex_pkg::instr_word_u w;
		logic [31:0] a;
		logic [31:0] b;
		int          kind;
		int          base;

		r_fn = '{ex_pkg::FN_ADD, ex_pkg::FN_ADDU, ex_pkg::FN_SUB,
			ex_pkg::FN_SUBU, ex_pkg::FN_AND, ex_pkg::FN_OR, ex_pkg::FN_XOR, ex_pkg::FN_NOR,
			ex_pkg::FN_SLT, ex_pkg::FN_SLTU, ex_pkg::FN_SLL, ex_pkg::FN_SRL, ex_pkg::FN_SRA,
			ex_pkg::FN_SLLV, ex_pkg::FN_SRLV, ex_pkg::FN_SRAV};
		i_op = '{ex_pkg::OP_ADDI, ex_pkg::OP_ADDIU, ex_pkg::OP_SLTI,
			ex_pkg::OP_SLTIU, ex_pkg::OP_ANDI, ex_pkg::OP_ORI, ex_pkg::OP_XORI, ex_pkg::OP_LUI};

		issue       = 1'b0;
		instr       = 32'd0;
		rs_data     = 32'd0;
		rt_data     = 32'd0;
		guess_taken = 1'b0;
		reset       = 1'b1;
		repeat (4) @(negedge clk);
		reset = 1'b0;

		base = errors;
		for (int i = 0; i < 200; i++) begin
			w    = 32'($random(seed));
			a    = $random(seed);
			b    = $random(seed);
			kind = $unsigned($random(seed)) % 3;
			if (kind == 0) begin
				w.r_fields.op    = ex_pkg::OP_SPECIAL;
				w.r_fields.funct = r_fn[$unsigned($random(seed)) % 16];
			end else if (kind == 1) begin
				w.i_fields.op = i_op[$unsigned($random(seed)) % 8];
			end else begin
				w.r_fields.op    = ex_pkg::OP_SPECIAL2;
				w.r_fields.funct = a[0] ? ex_pkg::FN_CLO : ex_pkg::FN_CLZ;
				// Spread the leading run length
				a = a[0] ? ~(b >> a[5:1]) : (b >> a[5:1]);
			end
			run_alu("alu", w, a, b);
		end
		report("random alu", base);

		base = errors;
		w = '0;
		w.r_fields.rd = 5'd3;
		w.r_fields.funct = ex_pkg::FN_ADD;
		run_alu("add ovf", w, 32'h7fffffff, 32'd1);
		w.r_fields.funct = ex_pkg::FN_ADDU;
		run_alu("addu", w, 32'h7fffffff, 32'd1);
		w.r_fields.funct = ex_pkg::FN_SUB;
		run_alu("sub ovf", w, 32'h80000000, 32'd1);
		w = '0;
		w.i_fields.op  = ex_pkg::OP_ADDI;
		w.i_fields.rt  = 5'd4;
		w.i_fields.imm = 16'h0001;
		run_alu("addi ovf", w, 32'h7fffffff, 32'd0);
		report("overflow", base);

		base = errors;
		br_word[0] = {ex_pkg::OP_BEQ, 26'd0};
		br_word[1] = {ex_pkg::OP_BNE, 26'd0};
		br_word[2] = {ex_pkg::OP_BLEZ, 26'd0};
		br_word[3] = {ex_pkg::OP_BGTZ, 26'd0};
		br_word[4] = {ex_pkg::OP_REGIMM, 5'd0, ex_pkg::RT_BLTZ, 16'd0};
		br_word[5] = {ex_pkg::OP_REGIMM, 5'd0, ex_pkg::RT_BGEZ, 16'd0};
		for (int c = 0; c < 6; c++) begin
			for (int k = 0; k < 8; k++) begin
				a = $random(seed);
				b = $random(seed);
				case (k % 4)
					0: a = 32'd0;
					1: a = a | 32'h80000000;
					2: b = a;
					default: ;
				endcase
				run_branch(br_word[c], a, b, k[2]);
			end
		end
		report("branch", base);

		base = errors;
		for (int i = 0; i < 12; i++) begin
			a = $random(seed);
			b = $random(seed);
			if (i % 3 == 1) begin
				b = b >> 20;
			end
			run_div(i[0], a, b, 1'b0);
		end
		run_div(1'b1, 32'h80000000, 32'hffffffff, 1'b0);
		run_div(1'b1, 32'd12345, 32'd0, 1'b0);
		run_div(1'b0, 32'd99, 32'd0, 1'b0);
		report("divide", base);

		base = errors;
		write_hilo(1'b1, 32'h13579bdf);
		write_hilo(1'b0, 32'h2468ace0);
		read_hilo("mfhi", 1'b1, model_hi);
		read_hilo("mflo", 1'b0, model_lo);
		report("hilo move", base);

		base = errors;
		run_div(1'b1, 32'hfffff000, 32'd7, 1'b1);
		report("issue while busy", base);

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

/* verilog/div_counter.sv */
`timescale 1ns/1ps
module div_counter (
	input  logic clk,
	input  logic reset,
	input  logic load,
	input  logic step,
	output logic last
);
	logic [4:0] count;

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= 5'd0;
		end else if (load) begin
			count <= 5'(ex_pkg::DIV_STEPS - 1);
		end else if (step && count != 5'd0) begin
			count <= count - 5'd1;
		end
	end

	// Zero marks the final iteration
	assign last = count == 5'd0;

endmodule

/* verilog/div_ctrl.sv */
`timescale 1ns/1ps
module div_ctrl (
	input  logic clk,
	input  logic reset,
	input  logic start,
	input  logic divisor_zero,
	input  logic cnt_last,
	output logic dp_load,
	output logic dp_step,
	output logic dp_finish,
	output logic cnt_load,
	output logic busy
);
	logic [1:0] state;
	logic [1:0] state_next;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ex_pkg::DIV_IDLE;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			ex_pkg::DIV_IDLE: begin
				// Zero divisor never starts
				if (start && !divisor_zero) begin
					state_next = ex_pkg::DIV_LOAD;
				end
			end
			ex_pkg::DIV_LOAD: state_next = ex_pkg::DIV_RUN;
			ex_pkg::DIV_RUN: begin
				if (cnt_last) begin
					state_next = ex_pkg::DIV_FIX;
				end
			end
			default: state_next = ex_pkg::DIV_IDLE;
		endcase
	end

	assign dp_load   = state == ex_pkg::DIV_LOAD;
	assign cnt_load  = state == ex_pkg::DIV_LOAD;
	assign dp_step   = state == ex_pkg::DIV_RUN;
	assign dp_finish = state == ex_pkg::DIV_FIX;
	assign busy      = state != ex_pkg::DIV_IDLE;

endmodule

/* verilog/div_datapath.sv */
`timescale 1ns/1ps
module div_datapath (
	input  logic        clk,
	input  logic        reset,
	input  logic        load,
	input  logic        step,
	input  logic        finish,
	input  logic        signed_op,
	input  logic [31:0] dividend,
	input  logic [31:0] divisor,
	output logic [31:0] quotient,
	output logic [31:0] remainder
);
	logic [31:0] rem;
	logic [31:0] quo;
	logic [31:0] dsr;
	logic        q_neg;
	logic        r_neg;
	logic        dvd_neg;
	logic        dsr_neg;
	logic [32:0] shifted;
	logic [33:0] trial;

	assign dvd_neg = signed_op & dividend[31];
	assign dsr_neg = signed_op & divisor[31];

	// Result signs, captured with the operands
	always_ff @(posedge clk) begin
		if (reset) begin
			q_neg <= 1'b0;
			r_neg <= 1'b0;
		end else if (load) begin
			q_neg <= dvd_neg ^ dsr_neg;
			r_neg <= dvd_neg;
		end
	end

	// Partial remainder with the next dividend bit shifted in
	assign shifted = {rem, quo[31]};
	assign trial   = {1'b0, shifted} - {2'b00, dsr};

	always_ff @(posedge clk) begin
		if (load) begin
			rem <= 32'd0;
			quo <= dvd_neg ? -dividend : dividend;
			dsr <= dsr_neg ? -divisor : divisor;
		end else if (step) begin
			if (trial[33]) begin
				// Restore, divisor did not fit
				rem <= shifted[31:0];
				quo <= {quo[30:0], 1'b0};
			end else begin
				rem <= trial[31:0];
				quo <= {quo[30:0], 1'b1};
			end
		end
	end

	// Sign correction applied in the finish cycle
	assign quotient  = (finish && q_neg) ? -quo : quo;
	assign remainder = (finish && r_neg) ? -rem : rem;

endmodule

/* verilog/ex_decode.sv */
`timescale 1ns/1ps
module ex_decode (
	input  ex_pkg::instr_word_u          instr,
	output logic [ex_pkg::ALU_OP_W-1:0]  alu_op,
	output logic                         srcb_imm,
	output logic                         imm_signed,
	output logic                         shamt_from_rs,
	output logic                         is_branch,
	output logic                         hi_we,
	output logic                         lo_we,
	output logic                         div_start,
	output logic                         div_signed,
	output logic                         writes_reg,
	output logic                         ovf_check,
	output logic [2:0]                   br_cond,
	output logic [1:0]                   out_sel,
	output logic [4:0]                   waddr
);

	always_comb begin
		alu_op        = ex_pkg::ALU_ADD;
		srcb_imm      = 1'b0;
		imm_signed    = 1'b0;
		shamt_from_rs = 1'b0;
		is_branch     = 1'b0;
		hi_we         = 1'b0;
		lo_we         = 1'b0;
		div_start     = 1'b0;
		div_signed    = 1'b0;
		writes_reg    = 1'b0;
		ovf_check     = 1'b0;
		br_cond       = ex_pkg::BR_EQ;
		out_sel       = ex_pkg::OUT_ALU;
		// I-type writes rt
		waddr         = instr.i_fields.rt;

		case (instr.r_fields.op)
			ex_pkg::OP_SPECIAL: begin
				waddr      = instr.r_fields.rd;
				writes_reg = 1'b1;
				case (instr.r_fields.funct)
					ex_pkg::FN_ADD: begin
						ovf_check = 1'b1;
					end
					ex_pkg::FN_ADDU: alu_op = ex_pkg::ALU_ADD;
					ex_pkg::FN_SUB: begin
						alu_op    = ex_pkg::ALU_SUB;
						ovf_check = 1'b1;
					end
					ex_pkg::FN_SUBU: alu_op = ex_pkg::ALU_SUB;
					ex_pkg::FN_AND:  alu_op = ex_pkg::ALU_AND;
					ex_pkg::FN_OR:   alu_op = ex_pkg::ALU_OR;
					ex_pkg::FN_XOR:  alu_op = ex_pkg::ALU_XOR;
					ex_pkg::FN_NOR:  alu_op = ex_pkg::ALU_NOR;
					ex_pkg::FN_SLT:  alu_op = ex_pkg::ALU_SLT;
					ex_pkg::FN_SLTU: alu_op = ex_pkg::ALU_SLTU;
					ex_pkg::FN_SLL:  alu_op = ex_pkg::ALU_SLL;
					ex_pkg::FN_SRL:  alu_op = ex_pkg::ALU_SRL;
					ex_pkg::FN_SRA:  alu_op = ex_pkg::ALU_SRA;
					ex_pkg::FN_SLLV: begin
						alu_op        = ex_pkg::ALU_SLL;
						shamt_from_rs = 1'b1;
					end
					ex_pkg::FN_SRLV: begin
						alu_op        = ex_pkg::ALU_SRL;
						shamt_from_rs = 1'b1;
					end
					ex_pkg::FN_SRAV: begin
						alu_op        = ex_pkg::ALU_SRA;
						shamt_from_rs = 1'b1;
					end
					ex_pkg::FN_MFHI: out_sel = ex_pkg::OUT_HI;
					ex_pkg::FN_MFLO: out_sel = ex_pkg::OUT_LO;
					ex_pkg::FN_MTHI: begin
						hi_we      = 1'b1;
						writes_reg = 1'b0;
					end
					ex_pkg::FN_MTLO: begin
						lo_we      = 1'b1;
						writes_reg = 1'b0;
					end
					ex_pkg::FN_DIV, ex_pkg::FN_DIVU: begin
						div_start  = 1'b1;
						div_signed = instr.r_fields.funct == ex_pkg::FN_DIV;
						writes_reg = 1'b0;
					end
					default: writes_reg = 1'b0;
				endcase
			end
			ex_pkg::OP_SPECIAL2: begin
				waddr      = instr.r_fields.rd;
				writes_reg = instr.r_fields.funct == ex_pkg::FN_CLZ ||
				             instr.r_fields.funct == ex_pkg::FN_CLO;
				alu_op     = instr.r_fields.funct[0] ? ex_pkg::ALU_CLO : ex_pkg::ALU_CLZ;
			end
			ex_pkg::OP_REGIMM: begin
				is_branch = instr.i_fields.rt == ex_pkg::RT_BLTZ ||
				            instr.i_fields.rt == ex_pkg::RT_BGEZ;
				br_cond   = instr.i_fields.rt[0] ? ex_pkg::BR_GEZ : ex_pkg::BR_LTZ;
			end
			ex_pkg::OP_BEQ, ex_pkg::OP_BNE, ex_pkg::OP_BLEZ, ex_pkg::OP_BGTZ: begin
				is_branch = 1'b1;
				// Low two opcode bits line up with EQ, NE, LEZ, GTZ
				br_cond   = {1'b0, instr.i_fields.op[1:0]};
			end
			ex_pkg::OP_ADDI, ex_pkg::OP_ADDIU: begin
				srcb_imm   = 1'b1;
				imm_signed = 1'b1;
				writes_reg = 1'b1;
				ovf_check  = instr.i_fields.op == ex_pkg::OP_ADDI;
			end
			ex_pkg::OP_SLTI, ex_pkg::OP_SLTIU: begin
				srcb_imm   = 1'b1;
				imm_signed = 1'b1;
				writes_reg = 1'b1;
				alu_op     = instr.i_fields.op[0] ? ex_pkg::ALU_SLTU : ex_pkg::ALU_SLT;
			end
			ex_pkg::OP_ANDI: begin
				srcb_imm   = 1'b1;
				writes_reg = 1'b1;
				alu_op     = ex_pkg::ALU_AND;
			end
			ex_pkg::OP_ORI: begin
				srcb_imm   = 1'b1;
				writes_reg = 1'b1;
				alu_op     = ex_pkg::ALU_OR;
			end
			ex_pkg::OP_XORI: begin
				srcb_imm   = 1'b1;
				writes_reg = 1'b1;
				alu_op     = ex_pkg::ALU_XOR;
			end
			ex_pkg::OP_LUI: begin
				srcb_imm   = 1'b1;
				writes_reg = 1'b1;
				alu_op     = ex_pkg::ALU_LUI;
			end
			default: begin
				writes_reg = 1'b0;
			end
		endcase
	end

endmodule

/* verilog/ex_pkg.sv */
package ex_pkg;

	// One instruction word, seen as R-type or I-type
	typedef union packed {
		struct packed {
			logic [5:0] op;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [4:0] rd;
			logic [4:0] sa;
			logic [5:0] funct;
		} r_fields;
		struct packed {
			logic [5:0]  op;
			logic [4:0]  rs;
			logic [4:0]  rt;
			logic [15:0] imm;
		} i_fields;
	} instr_word_u;

	// Primary opcodes
	localparam logic [5:0] OP_SPECIAL  = 6'b000000;
	localparam logic [5:0] OP_REGIMM   = 6'b000001;
	localparam logic [5:0] OP_BEQ      = 6'b000100;
	localparam logic [5:0] OP_BNE      = 6'b000101;
	localparam logic [5:0] OP_BLEZ     = 6'b000110;
	localparam logic [5:0] OP_BGTZ     = 6'b000111;
	localparam logic [5:0] OP_ADDI     = 6'b001000;
	localparam logic [5:0] OP_ADDIU    = 6'b001001;
	localparam logic [5:0] OP_SLTI     = 6'b001010;
	localparam logic [5:0] OP_SLTIU    = 6'b001011;
	localparam logic [5:0] OP_ANDI     = 6'b001100;
	localparam logic [5:0] OP_ORI      = 6'b001101;
	localparam logic [5:0] OP_XORI     = 6'b001110;
	localparam logic [5:0] OP_LUI      = 6'b001111;
	localparam logic [5:0] OP_SPECIAL2 = 6'b011100;

	// SPECIAL funct codes
	localparam logic [5:0] FN_SLL  = 6'b000000;
	localparam logic [5:0] FN_SRL  = 6'b000010;
	localparam logic [5:0] FN_SRA  = 6'b000011;
	localparam logic [5:0] FN_SLLV = 6'b000100;
	localparam logic [5:0] FN_SRLV = 6'b000110;
	localparam logic [5:0] FN_SRAV = 6'b000111;
	localparam logic [5:0] FN_MFHI = 6'b010000;
	localparam logic [5:0] FN_MTHI = 6'b010001;
	localparam logic [5:0] FN_MFLO = 6'b010010;
	localparam logic [5:0] FN_MTLO = 6'b010011;
	localparam logic [5:0] FN_DIV  = 6'b011010;
	localparam logic [5:0] FN_DIVU = 6'b011011;
	localparam logic [5:0] FN_ADD  = 6'b100000;
	localparam logic [5:0] FN_ADDU = 6'b100001;
	localparam logic [5:0] FN_SUB  = 6'b100010;
	localparam logic [5:0] FN_SUBU = 6'b100011;
	localparam logic [5:0] FN_AND  = 6'b100100;
	localparam logic [5:0] FN_OR   = 6'b100101;
	localparam logic [5:0] FN_XOR  = 6'b100110;
	localparam logic [5:0] FN_NOR  = 6'b100111;
	localparam logic [5:0] FN_SLT  = 6'b101010;
	localparam logic [5:0] FN_SLTU = 6'b101011;

	// SPECIAL2 funct codes
	localparam logic [5:0] FN_CLZ = 6'b100000;
	localparam logic [5:0] FN_CLO = 6'b100001;

	// REGIMM rt codes
	localparam logic [4:0] RT_BLTZ = 5'b00000;
	localparam logic [4:0] RT_BGEZ = 5'b00001;

	// ALU function selects
	localparam int ALU_OP_W = 5;
	localparam logic [ALU_OP_W-1:0] ALU_ADD  = 5'd0;
	localparam logic [ALU_OP_W-1:0] ALU_SUB  = 5'd1;
	localparam logic [ALU_OP_W-1:0] ALU_AND  = 5'd2;
	localparam logic [ALU_OP_W-1:0] ALU_OR   = 5'd3;
	localparam logic [ALU_OP_W-1:0] ALU_XOR  = 5'd4;
	localparam logic [ALU_OP_W-1:0] ALU_NOR  = 5'd5;
	localparam logic [ALU_OP_W-1:0] ALU_SLT  = 5'd6;
	localparam logic [ALU_OP_W-1:0] ALU_SLTU = 5'd7;
	localparam logic [ALU_OP_W-1:0] ALU_SLL  = 5'd8;
	localparam logic [ALU_OP_W-1:0] ALU_SRL  = 5'd9;
	localparam logic [ALU_OP_W-1:0] ALU_SRA  = 5'd10;
	localparam logic [ALU_OP_W-1:0] ALU_LUI  = 5'd11;
	localparam logic [ALU_OP_W-1:0] ALU_CLZ  = 5'd12;
	localparam logic [ALU_OP_W-1:0] ALU_CLO  = 5'd13;

	// Result source
	localparam logic [1:0] OUT_ALU = 2'd0;
	localparam logic [1:0] OUT_HI  = 2'd1;
	localparam logic [1:0] OUT_LO  = 2'd2;

	// Branch conditions
	localparam logic [2:0] BR_EQ  = 3'd0;
	localparam logic [2:0] BR_NE  = 3'd1;
	localparam logic [2:0] BR_LEZ = 3'd2;
	localparam logic [2:0] BR_GTZ = 3'd3;
	localparam logic [2:0] BR_LTZ = 3'd4;
	localparam logic [2:0] BR_GEZ = 3'd5;

	// Divider sequencing
	localparam int DIV_STEPS = 32;
	localparam logic [1:0] DIV_IDLE = 2'd0;
	localparam logic [1:0] DIV_LOAD = 2'd1;
	localparam logic [1:0] DIV_RUN  = 2'd2;
	localparam logic [1:0] DIV_FIX  = 2'd3;

endpackage

/* verilog/ex_stage.sv */
`timescale 1ns/1ps
module ex_stage (
	input  logic        clk,
	input  logic        reset,
	input  logic        issue,
	input  logic [31:0] instr,
	input  logic [31:0] rs_data,
	input  logic [31:0] rt_data,
	input  logic        guess_taken,
	output logic [31:0] result,
	output logic [4:0]  reg_waddr,
	output logic        result_valid,
	output logic        regwrite,
	output logic        overflow,
	output logic        branch_taken,
	output logic        mispredict,
	output logic        busy
);
	ex_pkg::instr_word_u         instr_u;
	logic [ex_pkg::ALU_OP_W-1:0] alu_op;
	logic                        srcb_imm;
	logic                        imm_signed;
	logic                        shamt_from_rs;
	logic                        is_branch;
	logic                        hi_we;
	logic                        lo_we;
	logic                        div_start;
	logic                        div_signed;
	logic                        writes_reg;
	logic                        ovf_check;
	logic [2:0]                  br_cond;
	logic [1:0]                  out_sel;
	logic [4:0]                  waddr;
	logic [31:0]                 imm_ext;
	logic [31:0]                 alu_srcb;
	logic [4:0]                  shamt;
	logic [31:0]                 alu_result;
	logic                        alu_ovf;
	logic                        ovf_trap;
	logic                        accept;
	logic                        dp_load;
	logic                        dp_step;
	logic                        dp_finish;
	logic                        cnt_load;
	logic                        cnt_last;
	logic [31:0]                 quotient;
	logic [31:0]                 remainder;
	logic [31:0]                 hi;
	logic [31:0]                 lo;
	logic [31:0]                 sel_result;
	logic                        rs_equal;
	logic                        rs_zero;
	logic                        rs_pos;
	logic                        br_hit;

	assign instr_u = instr;
	assign accept  = issue & ~busy;

	ex_decode decode_inst (
		.instr         (instr_u),
		.alu_op        (alu_op),
		.srcb_imm      (srcb_imm),
		.imm_signed    (imm_signed),
		.shamt_from_rs (shamt_from_rs),
		.is_branch     (is_branch),
		.hi_we         (hi_we),
		.lo_we         (lo_we),
		.div_start     (div_start),
		.div_signed    (div_signed),
		.writes_reg    (writes_reg),
		.ovf_check     (ovf_check),
		.br_cond       (br_cond),
		.out_sel       (out_sel),
		.waddr         (waddr)
	);

	// Immediate extension and operand steering
	assign imm_ext  = imm_signed ? {{16{instr_u.i_fields.imm[15]}}, instr_u.i_fields.imm}
	                             : {16'd0, instr_u.i_fields.imm};
	assign alu_srcb = srcb_imm ? imm_ext : rt_data;
	assign shamt    = shamt_from_rs ? rs_data[4:0] : instr_u.r_fields.sa;

	int_alu alu_inst (
		.alu_op (alu_op),
		.srca   (rs_data),
		.srcb   (alu_srcb),
		.shamt  (shamt),
		.result (alu_result),
		.ovf    (alu_ovf)
	);

	assign ovf_trap = ovf_check & alu_ovf;

	// Branch compare from equal, zero and positive flags of rs
	assign rs_equal = rs_data == rt_data;
	assign rs_zero  = rs_data == 32'd0;
	assign rs_pos   = ~rs_data[31] & ~rs_zero;

	always_comb begin
		case (br_cond)
			ex_pkg::BR_EQ:  br_hit = rs_equal;
			ex_pkg::BR_NE:  br_hit = ~rs_equal;
			ex_pkg::BR_LEZ: br_hit = ~rs_pos;
			ex_pkg::BR_GTZ: br_hit = rs_pos;
			ex_pkg::BR_LTZ: br_hit = ~rs_pos & ~rs_zero;
			ex_pkg::BR_GEZ: br_hit = rs_pos | rs_zero;
			default:        br_hit = 1'b0;
		endcase
		br_hit = br_hit & is_branch;
	end

	div_ctrl div_ctrl_inst (
		.clk          (clk),
		.reset        (reset),
		.start        (accept & div_start),
		.divisor_zero (rt_data == 32'd0),
		.cnt_last     (cnt_last),
		.dp_load      (dp_load),
		.dp_step      (dp_step),
		.dp_finish    (dp_finish),
		.cnt_load     (cnt_load),
		.busy         (busy)
	);

	div_counter div_counter_inst (
		.clk   (clk),
		.reset (reset),
		.load  (cnt_load),
		.step  (dp_step),
		.last  (cnt_last)
	);

	// Operands are held upstream while busy
	div_datapath div_datapath_inst (
		.clk       (clk),
		.reset     (reset),
		.load      (dp_load),
		.step      (dp_step),
		.finish    (dp_finish),
		.signed_op (div_signed),
		.dividend  (rs_data),
		.divisor   (rt_data),
		.quotient  (quotient),
		.remainder (remainder)
	);

	// HI and LO
	always_ff @(posedge clk) begin
		if (reset) begin
			hi <= 32'd0;
			lo <= 32'd0;
		end else if (dp_finish) begin
			hi <= remainder;
			lo <= quotient;
		end else if (accept) begin
			if (hi_we) begin
				hi <= rs_data;
			end
			if (lo_we) begin
				lo <= rs_data;
			end
		end
	end

	always_comb begin
		case (out_sel)
			ex_pkg::OUT_HI: sel_result = hi;
			ex_pkg::OUT_LO: sel_result = lo;
			default:        sel_result = alu_result;
		endcase
	end

	// Result flags, one cycle after issue
	always_ff @(posedge clk) begin
		if (reset) begin
			result_valid <= 1'b0;
			regwrite     <= 1'b0;
			overflow     <= 1'b0;
			branch_taken <= 1'b0;
			mispredict   <= 1'b0;
		end else begin
			result_valid <= accept & ~div_start;
			regwrite     <= accept & writes_reg & ~ovf_trap;
			overflow     <= accept & ovf_trap;
			branch_taken <= accept & br_hit;
			mispredict   <= accept & is_branch & (br_hit ^ guess_taken);
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			result    <= sel_result;
			reg_waddr <= waddr;
		end
	end

endmodule

/* verilog/int_alu.sv */
`timescale 1ns/1ps
module int_alu (
	input  logic [ex_pkg::ALU_OP_W-1:0] alu_op,
	input  logic [31:0]                 srca,
	input  logic [31:0]                 srcb,
	input  logic [4:0]                  shamt,
	output logic [31:0]                 result,
	output logic                        ovf
);
	logic [31:0] sum;
	logic [31:0] diff;
	logic [31:0] lead_src;
	logic [5:0]  lead_cnt;

	assign sum  = srca + srcb;
	assign diff = srca - srcb;

	// Signed overflow on add and subtract
	always_comb begin
		case (alu_op)
			ex_pkg::ALU_ADD: ovf = (srca[31] == srcb[31]) && (sum[31] != srca[31]);
			ex_pkg::ALU_SUB: ovf = (srca[31] != srcb[31]) && (diff[31] != srca[31]);
			default:         ovf = 1'b0;
		endcase
	end

	// Leading ones count as leading zeros of the inverse
	assign lead_src = (alu_op == ex_pkg::ALU_CLO) ? ~srca : srca;

	always_comb begin
		lead_cnt = 6'd32;
		for (int i = 0; i < 32; i++) begin
			if (lead_src[i]) begin
				lead_cnt = 6'd31 - 6'(i);
			end
		end
	end

	always_comb begin
		case (alu_op)
			ex_pkg::ALU_ADD:  result = sum;
			ex_pkg::ALU_SUB:  result = diff;
			ex_pkg::ALU_AND:  result = srca & srcb;
			ex_pkg::ALU_OR:   result = srca | srcb;
			ex_pkg::ALU_XOR:  result = srca ^ srcb;
			ex_pkg::ALU_NOR:  result = ~(srca | srcb);
			ex_pkg::ALU_SLT:  result = {31'd0, $signed(srca) < $signed(srcb)};
			ex_pkg::ALU_SLTU: result = {31'd0, srca < srcb};
			// Shifts act on rt, which arrives on srcb
			ex_pkg::ALU_SLL:  result = srcb << shamt;
			ex_pkg::ALU_SRL:  result = srcb >> shamt;
			ex_pkg::ALU_SRA:  result = $signed(srcb) >>> shamt;
			ex_pkg::ALU_LUI:  result = {srcb[15:0], 16'd0};
			ex_pkg::ALU_CLZ,
			ex_pkg::ALU_CLO:  result = {26'd0, lead_cnt};
			default:          result = 32'd0;
		endcase
	end

endmodule
